// File: design/fp_format_pkg.sv
package fp_format_pkg;

    ////////////////////////////////////////////////////////////
    // IEEE 754 single-precision field layout
    ////////////////////////////////////////////////////////////

    // Biased exponent field
    localparam int EXP_W = 8;
    // Stored mantissa, hidden bit not included
    localparam int MAN_W = 23;
    // Significand with the hidden bit in front
    localparam int SIG_W = MAN_W + 1;
    // Full significand product
    localparam int PROD_W = 2 * SIG_W;

    // Exponent bias and the reserved all-ones code
    localparam int EXP_BIAS = 127;
    localparam int EXP_MAX  = 255;

    // Signed working width for ea + eb - bias
    // Holds -126 up to 383 without wrap
    localparam int EXP_EXT_W = EXP_W + 2;

    ////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////

    // Packed value, sign at the top
    typedef logic [EXP_W+MAN_W:0] fp_word_t;

    typedef logic [EXP_W-1:0] exp_t;

    // Two's complement, compared as signed
    typedef logic signed [EXP_EXT_W-1:0] exp_ext_t;

    typedef logic [MAN_W-1:0]  man_t;
    typedef logic [SIG_W-1:0]  sig_t;
    typedef logic [PROD_W-1:0] prod_t;

endpackage

// File: design/fmul_result_pkg.sv
package fmul_result_pkg;

    ////////////////////////////////////////////////////////////
    // Result status flags
    ////////////////////////////////////////////////////////////

    // One bit per exception kind
    localparam int FLAG_W = 2;

    // Result exceeded the largest finite exponent
    // Output is then a signed infinity
    localparam int FLAG_OVF = 1;

    // Result fell below the smallest normal exponent
    // Output is then a signed zero
    localparam int FLAG_UNF = 0;

    // Flag vector, indexed by the positions above
    typedef logic [FLAG_W-1:0] flags_t;

endpackage

// File: design/fmul_stage_if.sv
`timescale 1ns/1ps

interface fmul_stage_if;
    import fp_format_pkg::*;
    import fmul_result_pkg::*;

    // From the exponent unit
    logic     sign;
    logic     zero;
    exp_ext_t exp_sum;
    exp_ext_t exp_inc;
    logic     ovf_sum;
    logic     unf_sum;
    logic     ovf_inc;
    logic     unf_inc;

    // From the significand multiplier
    prod_t    prod;

    // Range flags of one exponent variant
    // use_inc picks the +1 variant after a product carry
    function automatic flags_t range_flags(input logic use_inc);
        flags_t f;
        f           = '0;
        f[FLAG_OVF] = use_inc ? ovf_inc : ovf_sum;
        f[FLAG_UNF] = use_inc ? unf_inc : unf_sum;
        return f;
    endfunction

    modport exp_src (output sign, zero, exp_sum, exp_inc, ovf_sum, unf_sum, ovf_inc, unf_inc);

    modport sig_src (output prod);

    modport sink (
        input  sign, zero, exp_sum, exp_inc, ovf_sum, unf_sum, ovf_inc, unf_inc, prod,
        import range_flags
    );

endinterface

// File: design/fmul_exp_unit.sv
`timescale 1ns/1ps

module fmul_exp_unit (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               load_i,
    input  fp_format_pkg::exp_t exp_a_i,
    input  fp_format_pkg::exp_t exp_b_i,
    input  logic               sign_a_i,
    input  logic               sign_b_i,
    fmul_stage_if.exp_src      stage_o
);
    import fp_format_pkg::*;
    import fmul_result_pkg::*;

    ////////////////////////////////////////////////////////////
    // Range comparators
    ////////////////////////////////////////////////////////////

    // One comparator pair per exponent variant
    // At or above 255 is overflow, at or below 0 is underflow
    function automatic flags_t cmp_range(input exp_ext_t v);
        flags_t f;
        f           = '0;
        f[FLAG_OVF] = (v >= exp_ext_t'(EXP_MAX));
        f[FLAG_UNF] = (v <= exp_ext_t'(0));
        return f;
    endfunction

    exp_ext_t ext_a;
    exp_ext_t ext_b;
    exp_ext_t sum_d;
    exp_ext_t inc_d;
    flags_t   rng_sum;
    flags_t   rng_inc;
    logic     sign_d;
    logic     zero_d;

    // Sign of a product is the XOR of the operand signs
    assign sign_d = sign_a_i ^ sign_b_i;

    // Exponent field 0 means zero, denormals flushed too
    assign zero_d = (exp_a_i == '0) || (exp_b_i == '0);

    // Zero extend the fields into the signed width
    assign ext_a = exp_ext_t'({{(EXP_EXT_W-EXP_W){1'b0}}, exp_a_i});
    assign ext_b = exp_ext_t'({{(EXP_EXT_W-EXP_W){1'b0}}, exp_b_i});

    // Biased sum and the variant for a carry out of the product
    assign sum_d = ext_a + ext_b - exp_ext_t'(EXP_BIAS);
    assign inc_d = sum_d + exp_ext_t'(1);

    // A zero operand never raises a range flag
    assign rng_sum = zero_d ? '0 : cmp_range(sum_d);
    assign rng_inc = zero_d ? '0 : cmp_range(inc_d);

    ////////////////////////////////////////////////////////////
    // Stage 1 register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stage_o.sign    <= 1'b0;
            stage_o.zero    <= 1'b0;
            stage_o.exp_sum <= '0;
            stage_o.exp_inc <= '0;
            stage_o.ovf_sum <= 1'b0;
            stage_o.unf_sum <= 1'b0;
            stage_o.ovf_inc <= 1'b0;
            stage_o.unf_inc <= 1'b0;
        end else if (load_i) begin
            stage_o.sign    <= sign_d;
            stage_o.zero    <= zero_d;
            stage_o.exp_sum <= sum_d;
            stage_o.exp_inc <= inc_d;
            stage_o.ovf_sum <= rng_sum[FLAG_OVF];
            stage_o.unf_sum <= rng_sum[FLAG_UNF];
            stage_o.ovf_inc <= rng_inc[FLAG_OVF];
            stage_o.unf_inc <= rng_inc[FLAG_UNF];
        end
    end

endmodule

// File: design/fmul_sig_mult.sv
`timescale 1ns/1ps

module fmul_sig_mult (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                load_i,
    input  fp_format_pkg::man_t man_a_i,
    input  fp_format_pkg::man_t man_b_i,
    fmul_stage_if.sig_src       stage_o
);
    import fp_format_pkg::*;

    sig_t  sig_a;
    sig_t  sig_b;
    prod_t prod_d;

    // Hidden bit is always 1 for normal inputs
    // Zero operands are handled on the exponent side
    assign sig_a = {1'b1, man_a_i};
    assign sig_b = {1'b1, man_b_i};

    // Full 24 x 24 product, range [1.0, 4.0)
    // Bit 47 set means the product carried past 2.0
    assign prod_d = prod_t'(sig_a) * prod_t'(sig_b);

    ////////////////////////////////////////////////////////////
    // Stage 1 register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stage_o.prod <= '0;
        end else if (load_i) begin
            stage_o.prod <= prod_d;
        end
    end

endmodule

// File: design/fmul_normalize.sv
`timescale 1ns/1ps

module fmul_normalize (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     load_i,
    fmul_stage_if.sink               stage_i,
    output fp_format_pkg::fp_word_t  result_o,
    output fmul_result_pkg::flags_t  flags_o
);
    import fp_format_pkg::*;
    import fmul_result_pkg::*;

    logic     use_inc;
    exp_ext_t exp_sel;
    man_t     man_sel;
    flags_t   rng;
    fp_word_t result_d;
    flags_t   flags_d;

    ////////////////////////////////////////////////////////////
    // Normalization
    ////////////////////////////////////////////////////////////

    // Carry into the top bit, shift right by one
    assign use_inc = stage_i.prod[PROD_W-1];

    // Matching exponent variant from stage 1
    assign exp_sel = use_inc ? stage_i.exp_inc : stage_i.exp_sum;

    // Drop the hidden bit, truncate the rest
    assign man_sel = use_inc ? stage_i.prod[PROD_W-2 -: MAN_W]
                             : stage_i.prod[PROD_W-3 -: MAN_W];

    // Range flags of the chosen variant
    assign rng = stage_i.range_flags(use_inc);

    ////////////////////////////////////////////////////////////
    // Special case packing
    ////////////////////////////////////////////////////////////

    always_comb begin
        // Normal finite result as default
        result_d = {stage_i.sign, exp_sel[EXP_W-1:0], man_sel};
        flags_d  = '0;

        if (stage_i.zero) begin
            // Zero operand, signed zero, no flag
            result_d = {stage_i.sign, {EXP_W{1'b0}}, {MAN_W{1'b0}}};
        end else if (rng[FLAG_OVF]) begin
            // Signed infinity
            result_d          = {stage_i.sign, exp_t'(EXP_MAX), {MAN_W{1'b0}}};
            flags_d[FLAG_OVF] = 1'b1;
        end else if (rng[FLAG_UNF]) begin
            // No denormal output, flush to signed zero
            result_d          = {stage_i.sign, {EXP_W{1'b0}}, {MAN_W{1'b0}}};
            flags_d[FLAG_UNF] = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage 2 register
    ////////////////////////////////////////////////////////////

    // Holds steady while the pipe is stalled
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_o <= '0;
            flags_o  <= '0;
        end else if (load_i) begin
            result_o <= result_d;
            flags_o  <= flags_d;
        end
    end

endmodule

// File: design/fmul_pipe_ctrl.sv
`timescale 1ns/1ps

module fmul_pipe_ctrl (
    input  logic clk,
    input  logic arst_n_i,
    input  logic valid_i,
    input  logic ready_i,
    output logic valid_o,
    output logic ready_o,
    output logic advance_o
);

    logic valid_s1;
    logic valid_s2;
    logic advance;

    ////////////////////////////////////////////////////////////
    // Whole-pipe stall
    ////////////////////////////////////////////////////////////

    // Move when the output slot is empty or being taken
    // Otherwise every stage freezes
    assign advance = !valid_s2 || ready_i;

    // Valid bits shift one stage per advance
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
        end else if (advance) begin
            valid_s1 <= valid_i;
            valid_s2 <= valid_s1;
        end
    end

    // Input accepted exactly when the pipe moves
    assign ready_o   = advance;
    assign advance_o = advance;
    assign valid_o   = valid_s2;

endmodule

// File: design/fmul_top.sv
`timescale 1ns/1ps

module fmul_top (
    input  logic                    clk,
    input  logic                    arst_n_i,
    // Operand side
    input  logic                    valid_i,
    output logic                    ready_o,
    input  fp_format_pkg::fp_word_t a_i,
    input  fp_format_pkg::fp_word_t b_i,
    // Result side
    output logic                    valid_o,
    input  logic                    ready_i,
    output fp_format_pkg::fp_word_t result_o,
    output fmul_result_pkg::flags_t flags_o
);
    import fp_format_pkg::*;

    logic advance;

    // Operand fields, sign / exponent / mantissa
    logic sign_a;
    logic sign_b;
    exp_t exp_a;
    exp_t exp_b;
    man_t man_a;
    man_t man_b;

    assign sign_a = a_i[EXP_W+MAN_W];
    assign sign_b = b_i[EXP_W+MAN_W];
    assign exp_a  = a_i[MAN_W +: EXP_W];
    assign exp_b  = b_i[MAN_W +: EXP_W];
    assign man_a  = a_i[MAN_W-1:0];
    assign man_b  = b_i[MAN_W-1:0];

    // Stage 1 to stage 2 bundle
    fmul_stage_if stage ();

    ////////////////////////////////////////////////////////////
    // Flow control
    ////////////////////////////////////////////////////////////

    fmul_pipe_ctrl i_ctrl (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .valid_i   (valid_i),
        .ready_i   (ready_i),
        .valid_o   (valid_o),
        .ready_o   (ready_o),
        .advance_o (advance)
    );

    ////////////////////////////////////////////////////////////
    // Stage 1, exponent and significand in parallel
    ////////////////////////////////////////////////////////////

    fmul_exp_unit i_exp (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .load_i   (advance),
        .exp_a_i  (exp_a),
        .exp_b_i  (exp_b),
        .sign_a_i (sign_a),
        .sign_b_i (sign_b),
        .stage_o  (stage.exp_src)
    );

    fmul_sig_mult i_sig (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .load_i   (advance),
        .man_a_i  (man_a),
        .man_b_i  (man_b),
        .stage_o  (stage.sig_src)
    );

    // Stage 2 combiner
    fmul_normalize i_norm (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .load_i   (advance),
        .stage_i  (stage.sink),
        .result_o (result_o),
        .flags_o  (flags_o)
    );

endmodule

// File: dv/fmul_checker.sv
`timescale 1ns/1ps

module fmul_checker #(
    parameter int NAME_W = 160
) (
    input  logic                    clk,
    input  logic                    arst_n_i,
    // Input handshake and the table entry it carries
    input  logic                    in_valid_i,
    input  logic                    in_ready_i,
    input  int                      idx_i,
    input  logic [NAME_W-1:0]       name_i,
    input  fp_format_pkg::fp_word_t exp_result_i,
    input  fmul_result_pkg::flags_t exp_flags_i,
    // Output handshake
    input  logic                    out_valid_i,
    input  logic                    out_ready_i,
    input  fp_format_pkg::fp_word_t result_i,
    input  fmul_result_pkg::flags_t flags_i,
    // Running counts
    output int                      pass_cnt_o,
    output int                      fail_cnt_o,
    output int                      err_cnt_o
);
    import fp_format_pkg::*;
    import fmul_result_pkg::*;

    // Pending entries, oldest at the front
    int                idx_q[$];
    logic [NAME_W-1:0] name_q[$];
    fp_word_t          res_q[$];
    flags_t            flg_q[$];

    int       n_pass = 0;
    int       n_fail = 0;
    int       n_err  = 0;

    // Output seen stalled in the previous cycle
    logic     held = 1'b0;
    fp_word_t held_result;
    flags_t   held_flags;

    ////////////////////////////////////////////////////////////
    // Sampled on the clock edge, all inputs driven with NBA
    ////////////////////////////////////////////////////////////

    always @(posedge clk or negedge arst_n_i) begin
        int                idx;
        logic [NAME_W-1:0] nm;
        fp_word_t          want_res;
        flags_t            want_flg;
        if (!arst_n_i) begin
            idx_q.delete();
            name_q.delete();
            res_q.delete();
            flg_q.delete();
            held = 1'b0;
        end else begin
            // Stalled output must hold still
            if (held && (!out_valid_i || result_i !== held_result
                         || flags_i !== held_flags)) begin
                $display("Output changed or dropped while stalled by ready_i");
                n_err++;
            end
            held        = out_valid_i && !out_ready_i;
            held_result = result_i;
            held_flags  = flags_i;

            // Result accepted, compare with the oldest entry
            if (out_valid_i && out_ready_i) begin
                if (idx_q.size() == 0) begin
                    $display("Result %h accepted with no operand pair pending", result_i);
                    n_err++;
                end else begin
                    idx      = idx_q.pop_front();
                    nm       = name_q.pop_front();
                    want_res = res_q.pop_front();
                    want_flg = flg_q.pop_front();
                    if (result_i === want_res && flags_i === want_flg) begin
                        $display("PASS #%0d %s result %h flags %b",
                                 idx, nm, result_i, flags_i);
                        n_pass++;
                    end else begin
                        $display("CHECK FAILED #%0d %s expected %h flags %b actual %h flags %b",
                                 idx, nm, want_res, want_flg, result_i, flags_i);
                        n_fail++;
                    end
                end
            end

            // Operand pair accepted
            if (in_valid_i && in_ready_i) begin
                idx_q.push_back(idx_i);
                name_q.push_back(name_i);
                res_q.push_back(exp_result_i);
                flg_q.push_back(exp_flags_i);
            end
        end
        pass_cnt_o <= n_pass;
        fail_cnt_o <= n_fail;
        err_cnt_o  <= n_err;
    end

endmodule

// File: dv/fmul_tb.sv
`timescale 1ns/1ps

module fmul_tb;
    import fp_format_pkg::*;
    import fmul_result_pkg::*;

    localparam int MAX_CASES     = 32;
    localparam int NAME_W        = 8 * 20;
    localparam int READY_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 200;

    // Expected flag patterns, OVF at bit 1 and UNF at bit 0
    localparam flags_t NO_FLAG  = 2'b00;
    localparam flags_t OVF_FLAG = 2'b10;
    localparam flags_t UNF_FLAG = 2'b01;

    logic     clk;
    logic     arst_n_i;
    logic     valid_i;
    logic     ready_o;
    fp_word_t a_i;
    fp_word_t b_i;
    logic     valid_o;
    logic     ready_i;
    fp_word_t result_o;
    flags_t   flags_o;

    int seed = 29;

    // Stimulus table
    logic [NAME_W-1:0] case_name [MAX_CASES];
    fp_word_t          case_a    [MAX_CASES];
    fp_word_t          case_b    [MAX_CASES];
    fp_word_t          case_res  [MAX_CASES];
    flags_t            case_flg  [MAX_CASES];
    int                n_cases = 0;

    // Entry offered on the input right now
    int cur_idx;

    int pass_cnt;
    int fail_cnt;
    int err_cnt;

    fmul_top i_dut (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (valid_i),
        .ready_o  (ready_o),
        .a_i      (a_i),
        .b_i      (b_i),
        .valid_o  (valid_o),
        .ready_i  (ready_i),
        .result_o (result_o),
        .flags_o  (flags_o)
    );

    fmul_checker #(.NAME_W(NAME_W)) i_chk (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .in_valid_i   (valid_i),
        .in_ready_i   (ready_o),
        .idx_i        (cur_idx),
        .name_i       (case_name[cur_idx]),
        .exp_result_i (case_res[cur_idx]),
        .exp_flags_i  (case_flg[cur_idx]),
        .out_valid_i  (valid_o),
        .out_ready_i  (ready_i),
        .result_i     (result_o),
        .flags_i      (flags_o),
        .pass_cnt_o   (pass_cnt),
        .fail_cnt_o   (fail_cnt),
        .err_cnt_o    (err_cnt)
    );

    task automatic add_case(input logic [NAME_W-1:0] nm, input fp_word_t a, input fp_word_t b,
                            input fp_word_t res, input flags_t flg);
        case_name[n_cases] = nm;
        case_a[n_cases]    = a;
        case_b[n_cases]    = b;
        case_res[n_cases]  = res;
        case_flg[n_cases]  = flg;
        n_cases++;
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $finish;
    endtask

    ////////////////////////////////////////////////////////////
    // Cases, expected values worked out by hand
    ////////////////////////////////////////////////////////////

    task automatic load_cases();
        // Plain products, truncated
        add_case("one_p5_x_two",       32'h3FC00000, 32'h40000000, 32'h40400000, NO_FLAG);
        add_case("one_p25_sq_nocarry", 32'h3FA00000, 32'h3FA00000, 32'h3FC80000, NO_FLAG);
        add_case("one_p75_x_one_p25",  32'h3FE00000, 32'h3FA00000, 32'h400C0000, NO_FLAG);
        add_case("one_p5_sq_carry",    32'h3FC00000, 32'h3FC00000, 32'h40100000, NO_FLAG);
        add_case("max_sig_truncate",   32'h3FFFFFFF, 32'h3FFFFFFF, 32'h407FFFFE, NO_FLAG);
        // Sign
        add_case("neg_x_pos",          32'hBFC00000, 32'h40000000, 32'hC0400000, NO_FLAG);
        add_case("neg_x_neg",          32'hC0000000, 32'hBFC00000, 32'h40400000, NO_FLAG);
        // Zero operands, denormal counts as zero
        add_case("pos_zero_left",      32'h00000000, 32'h3FC00000, 32'h00000000, NO_FLAG);
        add_case("neg_zero_right",     32'h3FC00000, 32'h80000000, 32'h80000000, NO_FLAG);
        add_case("neg_x_pos_zero",     32'hBFC00000, 32'h00000000, 32'h80000000, NO_FLAG);
        add_case("zero_x_huge",        32'h00000000, 32'h7F000000, 32'h00000000, NO_FLAG);
        add_case("denormal_flushed",   32'h00400000, 32'h40000000, 32'h00000000, NO_FLAG);
        // Overflow, last one only through the product carry
        add_case("ovf_huge_sq",        32'h7F000000, 32'h7F000000, 32'h7F800000, OVF_FLAG);
        add_case("ovf_neg_huge",       32'hFF000000, 32'h7F000000, 32'hFF800000, OVF_FLAG);
        add_case("top_exp_no_carry",   32'h7F400000, 32'h3FA00000, 32'h7F700000, NO_FLAG);
        add_case("ovf_carry_only",     32'h7F400000, 32'h3FC00000, 32'h7F800000, OVF_FLAG);
        // Underflow, exponent sum exactly 0 and its carry rescue
        add_case("unf_tiny_sq",        32'h00800000, 32'h00800000, 32'h00000000, UNF_FLAG);
        add_case("unf_neg_tiny",       32'h80800000, 32'h00800000, 32'h80000000, UNF_FLAG);
        add_case("unf_exp_exactly_0",  32'h00800000, 32'h3F000000, 32'h00000000, UNF_FLAG);
        add_case("min_exp_via_carry",  32'h00C00000, 32'h3F400000, 32'h00900000, NO_FLAG);
    endtask

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Random back-pressure once out of reset
    initial begin
        forever begin
            @(posedge clk);
            if (arst_n_i) begin
                ready_i <= ($random(seed) & 3) != 0;
            end
        end
    end

    initial begin
        int waited;
        arst_n_i = 1'b0;
        valid_i  = 1'b0;
        a_i      = '0;
        b_i      = '0;
        ready_i  = 1'b0;
        cur_idx  = 0;
        load_cases();
        repeat (10) @(posedge clk);
        arst_n_i <= 1'b1;

        for (int i = 0; i < n_cases; i++) begin
            // Bubble before every third entry
            if (i % 3 == 2) begin
                valid_i <= 1'b0;
                @(posedge clk);
            end
            valid_i <= 1'b1;
            a_i     <= case_a[i];
            b_i     <= case_b[i];
            cur_idx <= i;
            waited = 0;
            @(posedge clk);
            while (!ready_o) begin
                waited++;
                if (waited > READY_TIMEOUT) begin
                    abort_run("ready_o stayed low too long while an operand pair was offered");
                end
                @(posedge clk);
            end
        end
        valid_i <= 1'b0;

        // Wait for every result
        waited = 0;
        while (pass_cnt + fail_cnt < n_cases) begin
            @(posedge clk);
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                abort_run("Not all results came out before the drain timeout");
            end
        end
        repeat (4) @(posedge clk);

        $display("Tests %0d, passed %0d, failed %0d, other errors %0d",
                 n_cases, pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0 && pass_cnt == n_cases) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: sim.f
design/fp_format_pkg.sv
design/fmul_result_pkg.sv
design/fmul_stage_if.sv
design/fmul_exp_unit.sv
design/fmul_sig_mult.sv
design/fmul_normalize.sv
design/fmul_pipe_ctrl.sv
design/fmul_top.sv
dv/fmul_checker.sv
dv/fmul_tb.sv

// File: Makefile
TOP       ?= fmul_tb
RTL_TOP   ?= fmul_top
SIM_F     ?= sim.f
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(SIM_F) --Mdir $(OBJ_DIR)

# Pass or fail comes from the log, not the exit code of the pipe
run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Simulation passed" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(TOP) -f $(SIM_F)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
